/* filelist.f */
+incdir+hdl
+incdir+tb
hdl/bpu_pkg.sv
hdl/bpu_update_if.sv
hdl/inst_decode.sv
hdl/tage_tagged_table.sv
hdl/tage_predictor.sv
hdl/btb.sv
hdl/target_select.sv
hdl/bpu_top.sv
tb/tb_bpu.sv

/* run.sh */
#!/bin/sh
# build and run with verilator, pass only if the log holds the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_bpu -f filelist.f -o tb_bpu_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_bpu_sim > sim.log 2>&1
grep -qx "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

/* tb/bpu_model.svh */
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

bpu_pkg::ctr_t      m_bim     [`BPU_BIM_ENTRIES];
bpu_pkg::ctr_t      m_t_ctr   [2][`BPU_TAGE_ENTRIES];     // [0] is T0, [1] is T1
bpu_pkg::tage_tag_t m_t_tag   [2][`BPU_TAGE_ENTRIES];
logic               m_btb_vld [`BPU_BTB_ENTRIES];
bpu_pkg::btb_tag_t  m_btb_tag [`BPU_BTB_ENTRIES];
bpu_pkg::addr_t     m_btb_tgt [`BPU_BTB_ENTRIES];
bpu_pkg::hist_t     m_hist;

task automatic model_reset();
    for (int i = 0; i < `BPU_BIM_ENTRIES; i++) begin
        m_bim[i] = 2'd1;
    end
    for (int i = 0; i < `BPU_TAGE_ENTRIES; i++) begin
        m_t_ctr[0][i] = 2'd1;
        m_t_ctr[1][i] = 2'd1;
        m_t_tag[0][i] = '0;
        m_t_tag[1][i] = '0;
    end
    for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
        m_btb_vld[i] = 1'b0;
    end
    m_hist = '0;
endtask

function automatic logic [7:0] tage_index(logic t, bpu_pkg::addr_t pc, bpu_pkg::hist_t h);
    return t ? pc[7:0] ^ h[15:8] : pc[7:0] ^ h[7:0];
endfunction

function automatic bpu_pkg::tage_tag_t tage_tag(logic t, bpu_pkg::addr_t pc, bpu_pkg::hist_t h);
    return t ? pc[17:8] ^ {2'b00, h[7:0]} : pc[17:8] ^ h[15:6];
endfunction

// only the top six tag bits take part in a lookup
function automatic logic tage_hit(logic t, bpu_pkg::addr_t pc, bpu_pkg::hist_t h);
    bpu_pkg::tage_tag_t tg;
    tg = tage_tag(t, pc, h);
    return m_t_tag[t][tage_index(t, pc, h)][9:4] == tg[9:4];
endfunction

function automatic bpu_pkg::ctr_t step_ctr(bpu_pkg::ctr_t c, logic taken);
    if (taken) begin
        return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
endfunction

function automatic logic model_dir(bpu_pkg::addr_t pc);
    if (tage_hit(1'b1, pc, m_hist)) begin
        return m_t_ctr[1][tage_index(1'b1, pc, m_hist)][1];
    end
    if (tage_hit(1'b0, pc, m_hist)) begin
        return m_t_ctr[0][tage_index(1'b0, pc, m_hist)][1];
    end
    return m_bim[pc[9:1]][1];
endfunction

task automatic model_predict(input bpu_pkg::addr_t pc, input logic [31:0] inst,
                             output logic br, output logic res, output bpu_pkg::addr_t npc);
    logic           btb_hit;
    bpu_pkg::addr_t b_off;
    bpu_pkg::addr_t j_off;
    btb_hit = m_btb_vld[pc[9:2]] && m_btb_tag[pc[9:2]] == pc[31:10];
    b_off   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    j_off   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    br  = 1'b0;
    res = 1'b0;
    npc = pc + 32'd4;
    case (inst[6:0])
        `BPU_OP_JAL: begin
            br  = 1'b1;
            res = 1'b1;
            npc = btb_hit ? m_btb_tgt[pc[9:2]] : pc + j_off;
        end
        `BPU_OP_JALR: begin
            br  = 1'b1;
            res = btb_hit;     // no target without the btb
            if (btb_hit) begin
                npc = m_btb_tgt[pc[9:2]];
            end
        end
        `BPU_OP_BRANCH: begin
            br  = 1'b1;
            res = model_dir(pc);
            if (res) begin
                npc = btb_hit ? m_btb_tgt[pc[9:2]] : pc + b_off;
            end
        end
        default: ;
    endcase
endtask

task automatic model_update(input logic taken, input logic correct, input bpu_pkg::addr_t pc,
                            input bpu_pkg::hist_t h, input bpu_pkg::addr_t tgt);
    logic [7:0] idx0;
    logic [7:0] idx1;
    logic       feq0;
    logic       feq1;
    idx0 = tage_index(1'b0, pc, h);
    idx1 = tage_index(1'b1, pc, h);
    feq0 = m_t_tag[0][idx0] == tage_tag(1'b0, pc, h);
    feq1 = m_t_tag[1][idx1] == tage_tag(1'b1, pc, h);
    if (tage_hit(1'b1, pc, h)) begin
        m_t_ctr[1][idx1] = correct ? step_ctr(m_t_ctr[1][idx1], taken) : {taken, taken};
    end else if (tage_hit(1'b0, pc, h)) begin
        m_t_ctr[0][idx0] = correct ? step_ctr(m_t_ctr[0][idx0], taken) : {taken, taken};
    end else if (!correct) begin
        // bimodal got it wrong, longer history first
        if (!feq1) begin
            m_t_tag[1][idx1] = tage_tag(1'b1, pc, h);
            m_t_ctr[1][idx1] = taken ? 2'd2 : 2'd1;
        end else if (!feq0) begin
            m_t_tag[0][idx0] = tage_tag(1'b0, pc, h);
            m_t_ctr[0][idx0] = taken ? 2'd2 : 2'd1;
        end
    end
    m_bim[pc[9:1]] = step_ctr(m_bim[pc[9:1]], taken);
    if (taken) begin
        m_btb_vld[pc[9:2]] = 1'b1;
        m_btb_tag[pc[9:2]] = pc[31:10];
        m_btb_tgt[pc[9:2]] = tgt;
    end
    m_hist = {m_hist[14:0], taken};
endtask

`endif

/* tb/tb_bpu.sv */
`timescale 1ns/10ps
`include "bpu_config.svh"

module tb_bpu;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 8;
    localparam int RAND_CYCLES  = 2000;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + IDLE_CYCLES + RAND_CYCLES + 50) * CLK_PERIOD;

    logic           clk;
    logic           rst;
    bpu_pkg::addr_t if_pc;
    logic [31:0]    if_inst;
    logic           ex_valid;
    logic           ex_taken;
    logic           ex_pdt_true;
    bpu_pkg::addr_t ex_pc;
    bpu_pkg::hist_t ex_history;
    bpu_pkg::addr_t ex_target;
    logic           branch_or_not;
    bpu_pkg::addr_t pdt_pc;
    logic           pdt_res;
    bpu_pkg::hist_t history;

    integer         seed = 32'h8254;
    bpu_pkg::addr_t pc_pool [16];
    logic [15:0]    pc_bias;        // usual outcome per pool entry

    `include "bpu_model.svh"

    bpu_top DUT (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc),
        .if_inst_i         (if_inst),
        .ex_branch_valid_i (ex_valid),
        .ex_branch_taken_i (ex_taken),
        .ex_pdt_true_i     (ex_pdt_true),
        .ex_pc_i           (ex_pc),
        .ex_history_i      (ex_history),
        .ex_target_i       (ex_target),
        .branch_or_not_o   (branch_or_not),
        .pdt_pc_o          (pdt_pc),
        .pdt_res_o         (pdt_res),
        .history_o         (history)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] draw();
        return $random(seed);
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_outputs();
        logic           exp_br;
        logic           exp_res;
        bpu_pkg::addr_t exp_pc;
        model_predict(if_pc, if_inst, exp_br, exp_res, exp_pc);
        check_value(32'(branch_or_not), 32'(exp_br), "branch_or_not_o");
        check_value(32'(pdt_res), 32'(exp_res), "pdt_res_o");
        check_value(pdt_pc, exp_pc, "pdt_pc_o");
        check_value(32'(history), 32'(m_hist), "history_o");
    endtask

    task automatic drive_random(input int cyc);
        logic [31:0] r;
        logic [31:0] inst;
        logic [31:0] tgt;
        int          mode;
        r    = draw();
        inst = draw();
        tgt  = draw();
        mode = (cyc / 200) % 3;    // all-taken and all-not-taken blocks repeat the history
        case (r[10:8])
            3'd4: inst[6:0] = `BPU_OP_JAL;
            3'd5: inst[6:0] = `BPU_OP_JALR;
            3'd6, 3'd7: ;           // random opcode, nearly always non-control
            default: inst[6:0] = `BPU_OP_BRANCH;
        endcase
        if_pc       <= pc_pool[r[3:0]];
        if_inst     <= inst;
        ex_valid    <= r[11] | r[12];
        ex_pc       <= pc_pool[r[7:4]];
        ex_pdt_true <= r[14:13] != 2'd0;
        ex_history  <= m_hist;
        ex_target   <= {tgt[31:2], 2'b00};
        case (mode)
            1: ex_taken <= 1'b1;
            2: ex_taken <= 1'b0;
            default: ex_taken <= (r[17:15] == 3'd0) ? !pc_bias[r[7:4]] : pc_bias[r[7:4]];
        endcase
    endtask

    initial begin
        logic [31:0] w;
        rst         <= 1'b1;
        if_pc       <= '0;
        if_inst     <= 32'h0000_0013;
        ex_valid    <= 1'b0;
        ex_taken    <= 1'b0;
        ex_pdt_true <= 1'b0;
        ex_pc       <= '0;
        ex_history  <= '0;
        ex_target   <= '0;
        model_reset();
        for (int i = 0; i < 16; i++) begin
            w = draw();
            pc_pool[i] = {w[31:2], 2'b00};
        end
        w = draw();
        pc_bias = w[15:0];
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // plain alu ops right after reset
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(posedge clk);
            w = draw();
            if_pc   <= pc_pool[i];
            if_inst <= {w[31:7], 7'b0010011};
            @(negedge clk);
            check_value(32'(history), 32'h0, "history_o after reset");
            compare_outputs();
        end

        for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
            @(posedge clk);
            if (ex_valid) begin
                model_update(ex_taken, ex_pdt_true, ex_pc, ex_history, ex_target);
            end
            drive_random(cyc);
            @(negedge clk);
            compare_outputs();
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error at %0t ns: watchdog expired before the test sequence finished", $time);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

/* hdl/bpu_top.sv */
`timescale 1ns/10ps
`include "bpu_config.svh"

module bpu_top (
    input  logic                 clk,
    input  logic                 rst,
    // fetch
    input  bpu_pkg::addr_t       if_pc_i,
    input  logic [`BPU_XLEN-1:0] if_inst_i,
    // execute resolution
    input  logic                 ex_branch_valid_i,
    input  logic                 ex_branch_taken_i,
    input  logic                 ex_pdt_true_i,
    input  bpu_pkg::addr_t       ex_pc_i,
    input  bpu_pkg::hist_t       ex_history_i,
    input  bpu_pkg::addr_t       ex_target_i,
    // prediction
    output logic                 branch_or_not_o,
    output bpu_pkg::addr_t       pdt_pc_o,
    output logic                 pdt_res_o,
    output bpu_pkg::hist_t       history_o
);

    bpu_pkg::inst_u      if_inst;
    bpu_pkg::inst_kind_e kind;
    bpu_pkg::addr_t      b_off, j_off, btb_target;
    logic                dir_taken, btb_hit;

    bpu_update_if upd_bus ();

    assign if_inst = if_inst_i;

    assign upd_bus.valid    = ex_branch_valid_i;
    assign upd_bus.taken    = ex_branch_taken_i;
    assign upd_bus.pdt_true = ex_pdt_true_i;
    assign upd_bus.pc       = ex_pc_i;
    assign upd_bus.history  = ex_history_i;
    assign upd_bus.target   = ex_target_i;

    inst_decode u_decode (
        .inst_i  (if_inst),
        .kind_o  (kind),
        .b_off_o (b_off),
        .j_off_o (j_off)
    );

    tage_predictor u_tage (
        .clk       (clk),
        .rst       (rst),
        .pc_i      (if_pc_i),
        .upd       (upd_bus.dst),
        .taken_o   (dir_taken),
        .history_o (history_o)
    );

    btb u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (if_pc_i),
        .upd      (upd_bus.dst),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    target_select u_select (
        .pc_i            (if_pc_i),
        .kind_i          (kind),
        .dir_taken_i     (dir_taken),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .b_off_i         (b_off),
        .j_off_i         (j_off),
        .branch_or_not_o (branch_or_not_o),
        .pdt_res_o       (pdt_res_o),
        .pdt_pc_o        (pdt_pc_o)
    );

endmodule

/* hdl/target_select.sv */
`timescale 1ns/10ps

module target_select (
    input  bpu_pkg::addr_t      pc_i,
    input  bpu_pkg::inst_kind_e kind_i,
    input  logic                dir_taken_i,
    input  logic                btb_hit_i,
    input  bpu_pkg::addr_t      btb_target_i,
    input  bpu_pkg::addr_t      b_off_i,
    input  bpu_pkg::addr_t      j_off_i,
    output logic                branch_or_not_o,
    output logic                pdt_res_o,
    output bpu_pkg::addr_t      pdt_pc_o
);

    localparam bpu_pkg::addr_t INST_BYTES = 4;

    bpu_pkg::addr_t seq_pc;

    assign seq_pc = pc_i + INST_BYTES;

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = seq_pc;   // fall through by default
        case (kind_i)
            bpu_pkg::KIND_JAL: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = 1'b1;
                pdt_pc_o        = btb_hit_i ? btb_target_i : pc_i + j_off_i;
            end
            bpu_pkg::KIND_JALR: begin
                // register target, nothing to compute here without the btb
                branch_or_not_o = 1'b1;
                pdt_res_o       = btb_hit_i;
                if (btb_hit_i) begin
                    pdt_pc_o = btb_target_i;
                end
            end
            bpu_pkg::KIND_BRANCH: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = dir_taken_i;
                if (dir_taken_i) begin
                    pdt_pc_o = btb_hit_i ? btb_target_i : pc_i + b_off_i;
                end
            end
            default: ;
        endcase
    end

endmodule

/* hdl/btb.sv */
`timescale 1ns/10ps
`include "bpu_config.svh"

module btb (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t pc_i,
    bpu_update_if.dst      upd,
    output logic           hit_o,
    output bpu_pkg::addr_t target_o
);

    localparam int IDX_W = $clog2(`BPU_BTB_ENTRIES);

    logic              valid_q  [`BPU_BTB_ENTRIES];
    bpu_pkg::btb_tag_t tag_q    [`BPU_BTB_ENTRIES];
    bpu_pkg::addr_t    target_q [`BPU_BTB_ENTRIES];

    logic [IDX_W-1:0]  lk_idx, up_idx;
    bpu_pkg::btb_tag_t lk_tag, up_tag;
    logic              wr_en;

    // word index pc[9:2], tag is everything above
    assign lk_idx = pc_i[IDX_W+1:2];
    assign lk_tag = pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_W];
    assign up_idx = upd.pc[IDX_W+1:2];
    assign up_tag = upd.pc[`BPU_XLEN-1 -: `BPU_BTB_TAG_W];

    assign wr_en = upd.valid && upd.taken;    // only taken branches install

    assign hit_o    = valid_q[lk_idx] && tag_q[lk_idx] == lk_tag;
    assign target_o = target_q[lk_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    // tag and target only mean something once valid is set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[up_idx]    <= up_tag;
            target_q[up_idx] <= upd.target;
        end
    end

    // a hit only reads an entry that a taken update has written
    a_hit_needs_valid: assert property (
        @(posedge clk) disable iff (rst) hit_o |-> !$isunknown(target_o)
    );

endmodule

/* hdl/tage_predictor.sv */
`timescale 1ns/10ps
`include "bpu_config.svh"

module tage_predictor (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t pc_i,
    bpu_update_if.dst      upd,
    output logic           taken_o,
    output bpu_pkg::hist_t history_o
);

    localparam int BIM_IDX_W = $clog2(`BPU_BIM_ENTRIES);

    bpu_pkg::ctr_t      bim_q [`BPU_BIM_ENTRIES];
    bpu_pkg::hist_t     ghist_q;
    bpu_pkg::provider_e up_prov;

    logic [BIM_IDX_W-1:0] lk_bim_idx, up_bim_idx;
    logic t0_lk_hit, t0_lk_taken, t0_up_hit, t0_full_eq;
    logic t1_lk_hit, t1_lk_taken, t1_up_hit, t1_full_eq;
    logic bim_miss;

    assign lk_bim_idx = pc_i[BIM_IDX_W:1];      // pc[9:1]
    assign up_bim_idx = upd.pc[BIM_IDX_W:1];

    tage_tagged_table #(.HIST_SEL(0)) t0_table (
        .clk              (clk),
        .rst              (rst),
        .lk_pc_i          (pc_i),
        .lk_hist_i        (ghist_q),
        .up_pc_i          (upd.pc),
        .up_hist_i        (upd.history),
        .upd_i            (upd.valid && up_prov == bpu_pkg::PROV_T0),
        .alloc_i          (bim_miss && t1_full_eq && !t0_full_eq),
        .correct_i        (upd.pdt_true),
        .taken_i          (upd.taken),
        .lk_hit_o         (t0_lk_hit),
        .lk_taken_o       (t0_lk_taken),
        .up_hit_o         (t0_up_hit),
        .up_full_tag_eq_o (t0_full_eq)
    );

    tage_tagged_table #(.HIST_SEL(1)) t1_table (
        .clk              (clk),
        .rst              (rst),
        .lk_pc_i          (pc_i),
        .lk_hist_i        (ghist_q),
        .up_pc_i          (upd.pc),
        .up_hist_i        (upd.history),
        .upd_i            (upd.valid && up_prov == bpu_pkg::PROV_T1),
        .alloc_i          (bim_miss && !t1_full_eq),
        .correct_i        (upd.pdt_true),
        .taken_i          (upd.taken),
        .lk_hit_o         (t1_lk_hit),
        .lk_taken_o       (t1_lk_taken),
        .up_hit_o         (t1_up_hit),
        .up_full_tag_eq_o (t1_full_eq)
    );

    // longest history wins
    assign taken_o = t1_lk_hit ? t1_lk_taken :
                     t0_lk_hit ? t0_lk_taken : bim_q[lk_bim_idx][1];

    // provider recomputed from the returned pc and history
    assign up_prov = t1_up_hit ? bpu_pkg::PROV_T1 :
                     t0_up_hit ? bpu_pkg::PROV_T0 : bpu_pkg::PROV_BIMODAL;
    assign bim_miss = upd.valid && !upd.pdt_true && up_prov == bpu_pkg::PROV_BIMODAL;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (upd.valid) begin
            ghist_q <= {ghist_q[`BPU_HIST_W-2:0], upd.taken};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BIM_ENTRIES; i++) begin
                bim_q[i] <= 2'd1;
            end
        end else if (upd.valid) begin
            if (upd.taken && bim_q[up_bim_idx] != 2'd3) begin
                bim_q[up_bim_idx] <= bim_q[up_bim_idx] + 2'd1;
            end else if (!upd.taken && bim_q[up_bim_idx] != 2'd0) begin
                bim_q[up_bim_idx] <= bim_q[up_bim_idx] - 2'd1;
            end
        end
    end

    assign history_o = ghist_q;

endmodule

/* hdl/tage_tagged_table.sv */
`timescale 1ns/10ps
`include "bpu_config.svh"

module tage_tagged_table #(
    parameter int HIST_SEL = 0  // 0 short hash (T0), 1 long hash (T1)
) (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t lk_pc_i,
    input  bpu_pkg::hist_t lk_hist_i,
    input  bpu_pkg::addr_t up_pc_i,
    input  bpu_pkg::hist_t up_hist_i,
    input  logic           upd_i,       // this table provided, train it
    input  logic           alloc_i,
    input  logic           correct_i,
    input  logic           taken_i,
    output logic           lk_hit_o,
    output logic           lk_taken_o,
    output logic           up_hit_o,
    output logic           up_full_tag_eq_o
);

    localparam int IDX_W  = $clog2(`BPU_TAGE_ENTRIES);
    localparam int TAG_W  = `BPU_TAG_W;
    localparam int PTAG_W = `BPU_PTAG_W;

    bpu_pkg::tage_tag_t tag_q [`BPU_TAGE_ENTRIES];
    bpu_pkg::ctr_t      ctr_q [`BPU_TAGE_ENTRIES];

    logic [IDX_W-1:0]   lk_idx, up_idx;
    bpu_pkg::tage_tag_t lk_tag, up_tag;

    function automatic logic [IDX_W-1:0] hash_idx(bpu_pkg::addr_t pc, bpu_pkg::hist_t h);
        return (HIST_SEL == 0) ? pc[IDX_W-1:0] ^ h[IDX_W-1:0]
                               : pc[IDX_W-1:0] ^ h[`BPU_HIST_W-1 -: IDX_W];
    endfunction

    function automatic bpu_pkg::tage_tag_t hash_tag(bpu_pkg::addr_t pc, bpu_pkg::hist_t h);
        return (HIST_SEL == 0) ? pc[IDX_W +: TAG_W] ^ h[`BPU_HIST_W-1 -: TAG_W]
                               : pc[IDX_W +: TAG_W] ^ {{(TAG_W-IDX_W){1'b0}}, h[IDX_W-1:0]};
    endfunction

    assign lk_idx = hash_idx(lk_pc_i, lk_hist_i);
    assign lk_tag = hash_tag(lk_pc_i, lk_hist_i);
    assign up_idx = hash_idx(up_pc_i, up_hist_i);
    assign up_tag = hash_tag(up_pc_i, up_hist_i);

    // partial match on the upper tag bits only
    assign lk_hit_o   = tag_q[lk_idx][TAG_W-1 -: PTAG_W] == lk_tag[TAG_W-1 -: PTAG_W];
    assign lk_taken_o = ctr_q[lk_idx][1];
    assign up_hit_o   = tag_q[up_idx][TAG_W-1 -: PTAG_W] == up_tag[TAG_W-1 -: PTAG_W];
    assign up_full_tag_eq_o = tag_q[up_idx] == up_tag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_TAGE_ENTRIES; i++) begin
                tag_q[i] <= '0;
                ctr_q[i] <= 2'd1;   // weakly not-taken
            end
        end else if (alloc_i) begin
            tag_q[up_idx] <= up_tag;
            ctr_q[up_idx] <= taken_i ? 2'd2 : 2'd1;
        end else if (upd_i) begin
            if (!correct_i) begin
                ctr_q[up_idx] <= taken_i ? 2'd3 : 2'd0;   // jump to strong
            end else if (taken_i && ctr_q[up_idx] != 2'd3) begin
                ctr_q[up_idx] <= ctr_q[up_idx] + 2'd1;
            end else if (!taken_i && ctr_q[up_idx] != 2'd0) begin
                ctr_q[up_idx] <= ctr_q[up_idx] - 2'd1;
            end
        end
    end

    // provider training and allocation come from different providers
    a_no_upd_alloc: assert property (@(posedge clk) disable iff (rst) !(upd_i && alloc_i));

endmodule

/* hdl/inst_decode.sv */
`timescale 1ns/10ps
`include "bpu_config.svh"

module inst_decode (
    input  bpu_pkg::inst_u      inst_i,
    output bpu_pkg::inst_kind_e kind_o,
    output bpu_pkg::addr_t      b_off_o,
    output bpu_pkg::addr_t      j_off_o
);

    // opcode sits in the same bits for both views
    always_comb begin
        case (inst_i.b_fmt.opcode)
            `BPU_OP_BRANCH: kind_o = bpu_pkg::KIND_BRANCH;
            `BPU_OP_JAL:    kind_o = bpu_pkg::KIND_JAL;
            `BPU_OP_JALR:   kind_o = bpu_pkg::KIND_JALR;
            default:        kind_o = bpu_pkg::KIND_OTHER;
        endcase
    end

    // 13-bit B offset, sign extended
    assign b_off_o = {{19{inst_i.b_fmt.imm12}},
                      inst_i.b_fmt.imm12,
                      inst_i.b_fmt.imm11,
                      inst_i.b_fmt.imm10_5,
                      inst_i.b_fmt.imm4_1,
                      1'b0};

    // 21-bit J offset, sign extended
    assign j_off_o = {{11{inst_i.j_fmt.imm20}},
                      inst_i.j_fmt.imm20,
                      inst_i.j_fmt.imm19_12,
                      inst_i.j_fmt.imm11,
                      inst_i.j_fmt.imm10_1,
                      1'b0};

    always_comb begin
        if (!$isunknown(inst_i)) begin
            assert (!$isunknown(kind_o))
                else $error("inst_decode: kind unknown for a known instruction");
        end
    end

endmodule

/* hdl/bpu_update_if.sv */
`timescale 1ns/10ps

// one resolved branch from execute, valid for a single cycle
interface bpu_update_if;

    logic           valid;
    logic           taken;
    logic           pdt_true;   // execute found the prediction right
    bpu_pkg::addr_t pc;
    bpu_pkg::hist_t history;    // history seen when this branch was predicted
    bpu_pkg::addr_t target;

    modport src (
        output valid,
        output taken,
        output pdt_true,
        output pc,
        output history,
        output target
    );

    modport dst (
        input valid,
        input taken,
        input pdt_true,
        input pc,
        input history,
        input target
    );

endinterface

/* hdl/bpu_pkg.sv */
`include "bpu_config.svh"

package bpu_pkg;

    typedef logic [`BPU_XLEN-1:0]      addr_t;
    typedef logic [`BPU_HIST_W-1:0]    hist_t;
    typedef logic [1:0]                ctr_t;      // msb set means taken
    typedef logic [`BPU_TAG_W-1:0]     tage_tag_t;
    typedef logic [`BPU_BTB_TAG_W-1:0] btb_tag_t;

    typedef enum logic [1:0] {
        KIND_OTHER,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR
    } inst_kind_e;

    typedef enum logic [1:0] {
        PROV_BIMODAL,
        PROV_T0,
        PROV_T1
    } provider_e;

    // same word seen as B-type or J-type
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_u;

endpackage

/* hdl/bpu_config.svh */
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// datapath widths
`define BPU_XLEN          32
`define BPU_HIST_W        16

// table geometry
`define BPU_BIM_ENTRIES   512
`define BPU_TAGE_ENTRIES  256
`define BPU_TAG_W         10
`define BPU_PTAG_W        6     // upper tag bits compared on lookup
`define BPU_BTB_ENTRIES   256
`define BPU_BTB_TAG_W     22    // pc[31:10]

// rv32 control-flow opcodes
`define BPU_OP_BRANCH     7'b1100011
`define BPU_OP_JAL        7'b1101111
`define BPU_OP_JALR       7'b1100111

`endif
